// ==== design/counter.sv ====
`timescale 1ns/1ps

module counter #(
    parameter int unsigned WIDTH          = 4,
    parameter bit          LATCH_OVERFLOW = 1'b0
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    // synchronous clear has the highest priority
    input  logic             clear_i,
    input  logic             en_i,
    // load d_i wins over enable
    input  logic             load_i,
    // count down when set, up otherwise
    input  logic             down_i,
    input  logic [WIDTH-1:0] d_i,
    output logic [WIDTH-1:0] q_o,
    output logic             overflow_o
);

    // one extra bit on top catches the carry or borrow
    logic [WIDTH:0] cnt_q;
    logic [WIDTH:0] cnt_d;

    always_comb begin
        cnt_d = cnt_q;
        if (clear_i) begin
            cnt_d = '0;
        end else if (load_i) begin
            cnt_d = {1'b0, d_i};
        end else if (en_i) begin
            if (down_i) begin
                cnt_d = cnt_q - 1'b1;
            end else begin
                cnt_d = cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    assign q_o = cnt_q[WIDTH-1:0];

    if (LATCH_OVERFLOW) begin : gen_sticky_ovf
        logic ovf_q;

        // set on the wrapping step and held until clear or load
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                ovf_q <= 1'b0;
            end else if (clear_i || load_i) begin
                ovf_q <= 1'b0;
            end else if (en_i && !ovf_q) begin
                if (down_i) begin
                    ovf_q <= (cnt_q[WIDTH-1:0] == '0);
                end else begin
                    ovf_q <= (cnt_q[WIDTH-1:0] == '1);
                end
            end
        end

        assign overflow_o = ovf_q;
    end else begin : gen_msb_ovf
        // carry/borrow bit straight out
        assign overflow_o = cnt_q[WIDTH];
    end

endmodule

// ==== design/ptg_consts.svh ====
`ifndef PTG_CONSTS_SVH
`define PTG_CONSTS_SVH

// width of the period and high-time fields
`define PTG_PERIOD_W 8

// width of the pulse count field
`define PTG_COUNT_W 8

// cycles per period allowed before the timer must reach zero,
// scaled by 256 in the controller check
`define PTG_ACK_TIMEOUT 2

`endif

// ==== design/ptg_ctrl.sv ====
`timescale 1ns/1ps
`include "ptg_consts.svh"

module ptg_ctrl (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       req_i,
    output logic       ack_o,
    output logic       busy_o,
    ptg_ctrl_if.ctrl   bus
);
    import ptg_pkg::*;

    // longest wait for a timer zero while running
    localparam int unsigned TMO_CYCLES = `PTG_ACK_TIMEOUT * 256;
    localparam int unsigned TMO_W      = $clog2(TMO_CYCLES + 1);

    ptg_state_e state_q;
    ptg_state_e state_d;

    logic tmr_zero;
    logic last_period;

    // cycles since the last timer zero in run
    logic [TMO_W-1:0] wait_q;

    assign tmr_zero    = (bus.tmr_q == '0);
    // period that ends now is the N-th one
    assign last_period = (bus.cnt_q == bus.last);

    always_comb begin
        state_d      = state_q;
        bus.cap      = 1'b0;
        bus.tmr_load = 1'b0;
        bus.tmr_en   = 1'b0;
        bus.cnt_clr  = 1'b0;
        bus.cnt_en   = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                // capture config, timer gets P-1, pulse count restarts
                bus.cap      = 1'b1;
                bus.tmr_load = 1'b1;
                bus.cnt_clr  = 1'b1;
                state_d      = RUN;
            end
            RUN: begin
                if (tmr_zero) begin
                    // one full period done
                    bus.cnt_en = 1'b1;
                    if (last_period) begin
                        state_d = ACK;
                    end else begin
                        bus.tmr_load = 1'b1;
                    end
                end else begin
                    bus.tmr_en = 1'b1;
                end
            end
            ACK: begin
                // host drops req to finish the handshake
                if (!req_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign bus.run = (state_q == RUN);
    assign ack_o   = (state_q == ACK);
    assign busy_o  = (state_q == LOAD) || (state_q == RUN);

    // saturating count that restarts at every zero and outside run
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q <= '0;
        end else if (!bus.run || tmr_zero) begin
            wait_q <= '0;
        end else if (wait_q != TMO_W'(TMO_CYCLES)) begin
            wait_q <= wait_q + 1'b1;
        end
    end

    // ack only answers a pending request
    a_ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(ack_o) |-> req_i
    ) else $error("ack raised without a pending request");

    // timer must keep hitting zero while the train runs
    a_period_ends: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        bus.run |-> (wait_q < TMO_W'(TMO_CYCLES))
    ) else $error("period timer stuck, no zero within timeout");

endmodule

// ==== design/ptg_ctrl_if.sv ====
`timescale 1ns/1ps

interface ptg_ctrl_if;
    import ptg_pkg::*;

    // controller strobes
    logic    cap;
    logic    tmr_load;
    logic    tmr_en;
    logic    cnt_clr;
    logic    cnt_en;
    logic    run;

    // counter values
    period_t tmr_q;
    count_t  cnt_q;

    // values derived from the captured config
    period_t reload;
    count_t  last;

    // controller side
    modport ctrl (
        output cap, tmr_load, tmr_en, cnt_clr, cnt_en, run,
        input  tmr_q, cnt_q, last
    );

    // config and waveform side
    modport wave (
        input  cap, run, tmr_q,
        output reload, last
    );

    // the two counters as wired at the top level
    modport cnt (
        input  tmr_load, tmr_en, reload, cnt_clr, cnt_en,
        output tmr_q, cnt_q
    );

endinterface

// ==== design/ptg_pkg.sv ====
`include "ptg_consts.svh"

package ptg_pkg;

    // period P, high time H or the live timer value
    typedef logic [`PTG_PERIOD_W-1:0] period_t;

    // pulse count N or the pulse counter value
    typedef logic [`PTG_COUNT_W-1:0] count_t;

    // controller states
    // idle waits for req, load captures the config for one cycle,
    // run generates the train, ack holds until req drops
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        RUN  = 2'd2,
        ACK  = 2'd3
    } ptg_state_e;

endpackage

// ==== design/ptg_top.sv ====
`timescale 1ns/1ps
`include "ptg_consts.svh"

module ptg_top (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             req_i,
    output logic             ack_o,
    input  ptg_pkg::period_t period_i,
    input  ptg_pkg::period_t high_i,
    input  ptg_pkg::count_t  count_i,
    output logic             pulse_o,
    output logic             busy_o
);

    // counting directions
    localparam logic TMR_DOWN = 1'b1;
    localparam logic CNT_DOWN = 1'b0;

    logic tmr_ovf;
    logic cnt_ovf;

    ptg_ctrl_if ctrl_if ();

    ptg_ctrl u_ctrl (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req_i  (req_i),
        .ack_o  (ack_o),
        .busy_o (busy_o),
        .bus    (ctrl_if.ctrl)
    );

    ptg_wave u_wave (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .period_i (period_i),
        .high_i   (high_i),
        .count_i  (count_i),
        .pulse_o  (pulse_o),
        .bus      (ctrl_if.wave)
    );

    // period timer reloaded with P-1 and run down to zero
    counter #(
        .WIDTH          (`PTG_PERIOD_W),
        .LATCH_OVERFLOW (1'b0)
    ) u_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (1'b0),
        .en_i       (ctrl_if.tmr_en),
        .load_i     (ctrl_if.tmr_load),
        .down_i     (TMR_DOWN),
        .d_i        (ctrl_if.reload),
        .q_o        (ctrl_if.tmr_q),
        .overflow_o (tmr_ovf)
    );

    // completed periods in the current train
    counter #(
        .WIDTH          (`PTG_COUNT_W),
        .LATCH_OVERFLOW (1'b1)
    ) u_pulses (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (ctrl_if.cnt_clr),
        .en_i       (ctrl_if.cnt_en),
        .load_i     (1'b0),
        .down_i     (CNT_DOWN),
        .d_i        ('0),
        .q_o        (ctrl_if.cnt_q),
        .overflow_o (cnt_ovf)
    );

    // timer never borrows past zero and pulse count never wraps
    a_no_wrap: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(tmr_ovf || cnt_ovf)
    ) else $error("counter wrap, timer=%0b pulses=%0b", tmr_ovf, cnt_ovf);

endmodule

// ==== design/ptg_wave.sv ====
`timescale 1ns/1ps

module ptg_wave (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  ptg_pkg::period_t period_i,
    input  ptg_pkg::period_t high_i,
    input  ptg_pkg::count_t  count_i,
    output logic            pulse_o,
    ptg_ctrl_if.wave        bus
);
    import ptg_pkg::*;

    // captured config turned into compare values
    period_t reload_q;
    period_t thresh_q;
    count_t  last_q;

    logic pulse_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reload_q <= '0;
            thresh_q <= '0;
            last_q   <= '0;
        end else if (bus.cap) begin
            reload_q <= period_t'(period_i - 1'b1);
            thresh_q <= period_t'(period_i - high_i);
            last_q   <= count_t'(count_i - 1'b1);
        end
    end

    // timer loads in the same cycle as the capture, so bypass then
    assign bus.reload = bus.cap ? period_t'(period_i - 1'b1) : reload_q;
    assign bus.last   = last_q;

    // high for the top H timer values which are the first H cycles of a period
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pulse_q <= 1'b0;
        end else begin
            pulse_q <= bus.run && (bus.tmr_q >= thresh_q);
        end
    end

    assign pulse_o = pulse_q;

    // legal config has 1 <= H < P, P >= 2 and N >= 1
    a_cfg_legal: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        bus.cap |-> (high_i < period_i) && (period_i > 1) &&
                    (high_i != '0) && (count_i != '0)
    ) else $error("illegal train config P=%0d H=%0d N=%0d", period_i, high_i, count_i);

endmodule

// ==== filelist.f ====
+incdir+design
design/ptg_pkg.sv
design/ptg_ctrl_if.sv
design/counter.sv
design/ptg_ctrl.sv
design/ptg_wave.sv
design/ptg_top.sv
test/tb_ptg.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pulse-train generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ptg \
    -f filelist.f \
    -o sim_ptg

./obj_dir/sim_ptg | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== test/tb_ptg.sv ====
`timescale 1ns/1ps

module tb_ptg;
    import ptg_pkg::*;

    localparam int NUM_TESTS = 17;

    // expected shape of one pulse train
    typedef struct packed {
        int width;
        int spacing;
        int pulses;
    } train_t;

    logic    clk_i = 1'b0;
    logic    rst_ni;
    logic    req_i;
    logic    ack_o;
    period_t period_i;
    period_t high_i;
    count_t  count_i;
    logic    pulse_o;
    logic    busy_o;

    int errors;
    int tests_passed;
    int tests_failed;
    int seed;
    longint budget_ns;
    bit budget_ready;

    // per-test config of P, H, N and cycles to hold req after ack
    int cfg_p[NUM_TESTS];
    int cfg_h[NUM_TESTS];
    int cfg_n[NUM_TESTS];
    int cfg_hold[NUM_TESTS];

    // pulse monitor state
    int mon_cycle;
    int mon_last_rise;
    int mon_high;
    int mon_pulses;
    int mon_ack_pulse;
    bit mon_prev;
    bit mon_seen;
    int width_q[$];
    int space_q[$];

    ptg_top ptg_top_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (req_i),
        .ack_o    (ack_o),
        .period_i (period_i),
        .high_i   (high_i),
        .count_i  (count_i),
        .pulse_o  (pulse_o),
        .busy_o   (busy_o)
    );

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    // high for the first h cycles of every period, n periods in total
    function automatic train_t expected_train(input int p, input int h, input int n);
        train_t t;
        t.width   = h;
        // rise to rise is one full period
        t.spacing = p;
        t.pulses  = n;
        return t;
    endfunction

    task automatic check_val(input string name, input int observed, input int expected);
        if (observed != expected) begin
            $display("ERR %0t ns %s observed %0d expected %0d", $time, name, observed, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic clear_monitor();
        mon_high      = 0;
        mon_pulses    = 0;
        mon_ack_pulse = 0;
        mon_seen      = 1'b0;
        width_q.delete();
        space_q.delete();
    endtask

    // sample at the falling edge where the DUT outputs have settled
    always @(negedge clk_i) begin
        mon_cycle++;
        if (pulse_o && !mon_prev) begin
            if (mon_seen) begin
                space_q.push_back(mon_cycle - mon_last_rise);
            end
            mon_last_rise = mon_cycle;
            mon_seen      = 1'b1;
            mon_high      = 1;
            mon_pulses++;
        end else if (pulse_o) begin
            mon_high++;
        end else if (mon_prev) begin
            width_q.push_back(mon_high);
        end
        // nothing may come out while ack is up
        if (pulse_o && ack_o) begin
            mon_ack_pulse++;
        end
        mon_prev = pulse_o;
    end

    task automatic run_train(input string name, input int p, input int h, input int n,
                             input int hold);
        train_t exp;
        int err_mark;
        int waited;
        err_mark = errors;
        exp      = expected_train(p, h, n);
        @(posedge clk_i);
        period_i <= period_t'(p);
        high_i   <= period_t'(h);
        count_i  <= count_t'(n);
        req_i    <= 1'b1;
        clear_monitor();
        // edge that samples req
        @(posedge clk_i);
        waited = 0;
        @(negedge clk_i);
        while (!ack_o) begin
            check_val("busy_o", int'(busy_o), 1);
            waited++;
            if (waited > p * n + 10) begin
                $display("test %s: ack_o did not rise within %0d cycles", name, waited);
                errors++;
                report_test(name, err_mark);
                return;
            end
            @(negedge clk_i);
        end
        // ack holds as long as req stays up
        repeat (hold) begin
            @(negedge clk_i);
            check_val("ack_o", int'(ack_o), 1);
        end
        @(posedge clk_i);
        req_i <= 1'b0;
        @(negedge clk_i);
        check_val("ack_o", int'(ack_o), 1);
        // ack drops on the edge that samples req low
        @(posedge clk_i);
        @(negedge clk_i);
        check_val("ack_o", int'(ack_o), 0);
        check_val("busy_o", int'(busy_o), 0);
        check_val("pulse_count", mon_pulses, exp.pulses);
        check_val("width_samples", width_q.size(), exp.pulses);
        foreach (width_q[w]) begin
            check_val("high_width", width_q[w], exp.width);
        end
        check_val("spacing_samples", space_q.size(), exp.pulses - 1);
        foreach (space_q[s]) begin
            check_val("spacing", space_q[s], exp.spacing);
        end
        check_val("pulse_in_ack", mon_ack_pulse, 0);
        report_test(name, err_mark);
    endtask

    task automatic check_idle_outputs();
        check_val("ack_o", int'(ack_o), 0);
        check_val("busy_o", int'(busy_o), 0);
        check_val("pulse_o", int'(pulse_o), 0);
    endtask

    // global limit from the total train length
    initial begin
        wait (budget_ready);
        #(budget_ns);
        $display("watchdog: run did not finish within %0d ns", budget_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        int err_mark;
        int r;
        rst_ni   = 1'b0;
        req_i    = 1'b0;
        period_i = '0;
        high_i   = '0;
        count_i  = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        mon_cycle    = 0;
        mon_prev     = 1'b0;
        clear_monitor();
        seed = 70893;

        // 0 reset, 1 fixed, 2 handshake, 3..4 edge values, 5.. random
        cfg_p = '{default: 0};
        cfg_h = '{default: 0};
        cfg_n = '{default: 0};
        cfg_hold = '{default: 1};
        cfg_p[1] = 5;
        cfg_h[1] = 2;
        cfg_n[1] = 3;
        cfg_p[2] = 4;
        cfg_h[2] = 1;
        cfg_n[2] = 2;
        r = $random(seed);
        cfg_hold[2] = 1 + int'($unsigned(r) % 32'd8);
        cfg_p[3] = 2;
        cfg_h[3] = 1;
        cfg_n[3] = 1;
        cfg_p[4] = 255;
        cfg_h[4] = 254;
        cfg_n[4] = 2;
        for (int i = 5; i < NUM_TESTS; i++) begin
            r = $random(seed);
            cfg_p[i] = 2 + int'($unsigned(r) % 32'd254);
            r = $random(seed);
            cfg_h[i] = 1 + int'($unsigned(r) % 32'(cfg_p[i] - 1));
            r = $random(seed);
            cfg_n[i] = 1 + int'($unsigned(r) % 32'd255);
            r = $random(seed);
            cfg_hold[i] = int'($unsigned(r) % 32'd4);
        end
        budget_ns = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            budget_ns += longint'((cfg_p[i] * cfg_n[i] + 20) * 20);
        end
        budget_ready = 1'b1;

        // outputs stay quiet through reset and until the first request
        err_mark = errors;
        repeat (4) begin
            @(negedge clk_i);
            check_idle_outputs();
        end
        @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            check_idle_outputs();
        end
        report_test("reset", err_mark);

        run_train("fixed", cfg_p[1], cfg_h[1], cfg_n[1], cfg_hold[1]);
        run_train("handshake", cfg_p[2], cfg_h[2], cfg_n[2], cfg_hold[2]);
        run_train("edge_short", cfg_p[3], cfg_h[3], cfg_n[3], cfg_hold[3]);
        run_train("edge_long", cfg_p[4], cfg_h[4], cfg_n[4], cfg_hold[4]);
        for (int i = 5; i < NUM_TESTS; i++) begin
            run_train($sformatf("random_%0d", i - 4), cfg_p[i], cfg_h[i], cfg_n[i],
                      cfg_hold[i]);
        end

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
